//--- design/passthru_pkg.sv
// constants, apb and pin structs, led modes and register map
// shared by the esp32 / flash passthrough bridge
package passthru_pkg;

  localparam int unsigned POWERUP_HOLD_LOG2    = 4;  // en low for 2^4 cycles
  localparam int unsigned TIMEOUT_LOG2_DEFAULT = 26; // ~2.7 s at 25 MHz
  localparam int unsigned TIMEOUT_LOG2_MAX     = 26; // widest release counter
  localparam int unsigned STRETCH_CYCLES       = 8;  // led activity pulse

  // register map, byte addresses
  localparam logic [3:0] ADDR_CTRL   = 4'h0;
  localparam logic [3:0] ADDR_STATUS = 4'h4;
  localparam logic [3:0] ADDR_FRAMES = 4'h8;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic ndtr; // active low, from usb chip
    logic nrts;
  } modem_t;

  typedef struct packed {
    logic flash_reset; // stops sck to the flash
    logic esp_hold;    // holds esp32 in reset
  } btn_t;

  typedef enum logic [1:0] {
    LED_SPI    = 2'd0,
    LED_BOOT   = 2'd1,
    LED_SERIAL = 2'd2,
    LED_OFF    = 2'd3
  } led_mode_e;

  typedef struct packed {
    logic       esp_hold;
    logic [4:0] timeout_log2;
    led_mode_e  led_mode;
  } ctrl_t;

  typedef struct packed {
    logic prog_active;  // straps driven
    logic en_released;  // en left to pull-up
    logic powerup_done;
  } status_t;

  // value and output enable per esp32 pin, oe 0 means pull-up
  typedef struct packed {
    logic en;
    logic en_oe;
    logic gpio0;
    logic gpio0_oe;
    logic gpio2;
    logic gpio2_oe;
    logic gpio4;
    logic gpio4_oe;
    logic gpio12;
    logic gpio12_oe;
    logic gpio13;
    logic gpio13_oe;
  } boot_drive_t;

  typedef struct packed {
    logic sck;
    logic mosi;
    logic csn;
  } spi_bus_t;

endpackage

//--- design/sync_stage.sv
// two-flop synchronizer for a bundle of asynchronous board inputs
`timescale 1ns/1ps

module sync_stage #(
  parameter type T = logic
) (
  input  logic clk_25mhz,
  input  logic rst,
  input  T     d,
  output T     q
);

  T meta; // first stage, may go metastable

  // inputs idle high, so both stages come out of reset as ones
  always_ff @(posedge clk_25mhz)
  begin
    if (rst)
    begin
      meta <= '1;
      q    <= '1;
    end
    else
    begin
      meta <= d;
      q    <= meta; // settled copy
    end
  end

endmodule

//--- design/esp32_boot_ctrl.sv
// esp32 boot control: dtr/rts decode, power-up en hold
// and strap release timeout, all pin drive registered
`timescale 1ns/1ps

module esp32_boot_ctrl (
  input  logic                      clk_25mhz,
  input  logic                      rst,
  input  passthru_pkg::modem_t      modem,        // already synchronized
  input  logic                      esp_hold_btn, // already synchronized
  input  passthru_pkg::ctrl_t       ctrl,
  output passthru_pkg::boot_drive_t drive,
  output passthru_pkg::status_t     status
);
  import passthru_pkg::*;

  logic [1:0]                  lines;     // {ndtr, nrts}
  logic [1:0]                  lines_q;   // previous state, for entry detect
  logic                        en_dec;    // 0 = en wanted low
  logic                        io0_dec;
  logic                        entry;     // rising entry into 10
  logic                        en_low;
  logic [TIMEOUT_LOG2_MAX:0]   limit;
  logic [TIMEOUT_LOG2_MAX:0]   rel_cnt;
  logic [TIMEOUT_LOG2_MAX:0]   rel_next;
  logic                        prog;      // straps currently driven
  logic                        prog_next;
  logic [POWERUP_HOLD_LOG2:0]  pu_cnt;
  logic                        pu_done;

  assign lines = {modem.ndtr, modem.nrts};

  // dtr rts -> en io0
  //  1   0     0   1   reset, boot mode
  //  0   1     1   0   run, io0 low
  //  other     1   1
  always_comb
  begin
    unique case (lines)
      2'b10:   {en_dec, io0_dec} = 2'b01;
      2'b01:   {en_dec, io0_dec} = 2'b10;
      default: {en_dec, io0_dec} = 2'b11;
    endcase
  end

  assign entry   = (lines == 2'b10) && (lines_q != 2'b10);
  assign pu_done = pu_cnt[POWERUP_HOLD_LOG2]; // msb set after 2^n cycles
  assign limit   = (TIMEOUT_LOG2_MAX + 1)'(1) << ctrl.timeout_log2;
  assign en_low  = !pu_done || ctrl.esp_hold || esp_hold_btn || !en_dec;

  // release counter, restarts on entry, stops once limit reached
  always_comb
  begin
    rel_next  = rel_cnt;
    prog_next = prog;
    if (entry)
    begin
      rel_next  = '0;
      prog_next = 1'b1;
    end
    else if (prog)
    begin
      rel_next  = rel_cnt + 1'b1;
      prog_next = rel_next < limit; // drop straps when count hits 2^n
    end
  end

  always_ff @(posedge clk_25mhz)
  begin
    if (rst)
    begin
      lines_q <= 2'b11;
      rel_cnt <= '1;   // starts saturated, no straps after reset
      prog    <= 1'b0;
      pu_cnt  <= '0;
      drive   <= '0;
      drive.en_oe <= 1'b1; // en pulled low during power-up hold
    end
    else
    begin
      lines_q <= lines;
      rel_cnt <= rel_next;
      prog    <= prog_next;
      if (!pu_done)
        pu_cnt <= pu_cnt + 1'b1;
      drive.en        <= 1'b0;  // en is only ever pulled low
      drive.en_oe     <= en_low;
      drive.gpio0     <= io0_dec;
      drive.gpio0_oe  <= prog_next;
      drive.gpio2     <= io0_dec; // follows gpio0 for download mode
      drive.gpio2_oe  <= prog_next;
      drive.gpio4     <= 1'b1;
      drive.gpio4_oe  <= prog_next;
      drive.gpio12    <= 1'b0;  // flash voltage strap, never 1
      drive.gpio12_oe <= prog_next;
      drive.gpio13    <= 1'b1;
      drive.gpio13_oe <= prog_next;
    end
  end

  assign status.prog_active  = prog;
  assign status.en_released  = !drive.en_oe;
  assign status.powerup_done = pu_done;

endmodule

//--- design/flash_spi_bridge.sv
// spi passthrough to config flash, sck gating and csn frame counter
`timescale 1ns/1ps

module flash_spi_bridge (
  input  logic                   clk_25mhz,
  input  logic                   rst,
  input  logic                   flash_reset,  // synchronized button
  input  passthru_pkg::spi_bus_t host,
  output logic                   host_miso,
  output passthru_pkg::spi_bus_t flash,
  input  logic                   flash_miso,
  output logic                   flash_wpn,
  output logic                   flash_holdn,
  input  logic                   frames_clear,
  output logic [15:0]            frame_count
);

  logic csn_meta; // host csn is asynchronous
  logic csn_q;
  logic csn_qq;
  logic frame_end;

  // data path purely combinational
  assign flash.sck   = flash_reset ? 1'b0 : host.sck;
  assign flash.mosi  = host.mosi;
  assign flash.csn   = host.csn;
  assign host_miso   = flash_miso;
  assign flash_wpn   = 1'b1; // no write protect
  assign flash_holdn = 1'b1; // never paused

  assign frame_end = csn_q && !csn_qq; // csn rising ends a frame

  always_ff @(posedge clk_25mhz)
  begin
    if (rst)
    begin
      csn_meta    <= 1'b1;
      csn_q       <= 1'b1;
      csn_qq      <= 1'b1;
      frame_count <= '0;
    end
    else
    begin
      csn_meta <= host.csn;
      csn_q    <= csn_meta;
      csn_qq   <= csn_q;
      if (frames_clear)
        frame_count <= '0;
      else if (frame_end && (frame_count != 16'hffff))
        frame_count <= frame_count + 1'b1; // saturates
    end
  end

endmodule

//--- design/apb_ctrl_regs.sv
// apb slave with ctrl, status and frame count registers
// zero wait states, unmapped addresses flag pslverr
`timescale 1ns/1ps

module apb_ctrl_regs (
  input  logic                   clk_25mhz,
  input  logic                   rst,
  input  passthru_pkg::apb_req_t req,
  output passthru_pkg::apb_rsp_t rsp,
  output passthru_pkg::ctrl_t    ctrl,
  input  passthru_pkg::status_t  status,
  input  logic [15:0]            frame_count,
  output logic                   frames_clear
);
  import passthru_pkg::*;

  logic       access;     // access phase
  logic       wr_en;
  logic       sel_ctrl;
  logic       sel_status;
  logic       sel_frames;
  logic       mapped;
  logic [4:0] wr_log2;    // clipped exponent

  assign access     = req.psel && req.penable;
  assign wr_en      = access && req.pwrite;
  assign sel_ctrl   = (req.paddr == ADDR_CTRL);
  assign sel_status = (req.paddr == ADDR_STATUS);
  assign sel_frames = (req.paddr == ADDR_FRAMES);
  assign mapped     = sel_ctrl || sel_status || sel_frames;

  // counter cannot go wider than the max exponent
  assign wr_log2 = (req.pwdata[12:8] > 5'(TIMEOUT_LOG2_MAX)) ?
                   5'(TIMEOUT_LOG2_MAX) : req.pwdata[12:8];

  always_ff @(posedge clk_25mhz)
  begin
    if (rst)
    begin
      ctrl.esp_hold     <= 1'b0;
      ctrl.timeout_log2 <= 5'(TIMEOUT_LOG2_DEFAULT);
      ctrl.led_mode     <= LED_SPI;
    end
    else if (wr_en && sel_ctrl)
    begin
      ctrl.esp_hold     <= req.pwdata[0];
      ctrl.timeout_log2 <= wr_log2;
      ctrl.led_mode     <= led_mode_e'(req.pwdata[17:16]);
    end
  end

  // write of any value clears the count, one cycle since pready is tied high
  assign frames_clear = wr_en && sel_frames;

  // read mux, status writes just fall through
  always_comb
  begin
    rsp.prdata = '0;
    if (sel_ctrl)
    begin
      rsp.prdata[0]     = ctrl.esp_hold;
      rsp.prdata[12:8]  = ctrl.timeout_log2;
      rsp.prdata[17:16] = ctrl.led_mode;
    end
    else if (sel_status)
      rsp.prdata[2:0] = status;
    else if (sel_frames)
      rsp.prdata[15:0] = frame_count;
  end

  assign rsp.pready  = 1'b1;
  assign rsp.pslverr = access && !mapped; // only in access phase

endmodule

//--- design/led_status_mux.sv
// led source select, spi and serial activity pulse stretchers
`timescale 1ns/1ps

module led_status_mux (
  input  logic                    clk_25mhz,
  input  logic                    rst,
  input  passthru_pkg::led_mode_e mode,
  input  passthru_pkg::spi_bus_t  host,
  input  logic                    host_miso,
  input  passthru_pkg::status_t   status,
  input  logic                    serial_rx,
  input  logic                    serial_tx,
  output logic [7:0]              led
);
  import passthru_pkg::*;

  logic [5:0]                     act_in;  // tx rx ~csn miso mosi sck
  logic [5:0]                     act_q;
  logic [5:0]                     act_qq;
  logic [5:0][STRETCH_CYCLES-1:0] stretch; // ones drain out from the top
  logic [5:0]                     act;

  assign act_in = {serial_tx, serial_rx, !host.csn, host_miso, host.mosi, host.sck};

  // sample only, a glitch at most lights an led
  always_ff @(posedge clk_25mhz)
  begin
    act_q  <= act_in;
    act_qq <= act_q;
  end

  always_ff @(posedge clk_25mhz)
  begin
    if (rst)
      stretch <= '0;
    else
      for (int i = 0; i < 6; i++)
        stretch[i] <= (act_q[i] != act_qq[i]) ? '1 : (stretch[i] >> 1);
  end

  always_comb
  begin
    for (int i = 0; i < 6; i++)
      act[i] = stretch[i][0]; // high for STRETCH_CYCLES after a change
  end

  always_comb
  begin
    led = '0; // unused bits off
    case (mode)
      LED_SPI:    led[3:0] = act[3:0];
      LED_BOOT:   led[2:0] = status;
      LED_SERIAL: led[1:0] = act[5:4];
      LED_OFF:    led      = '0;
      default:    led      = '0;
    endcase
  end

endmodule

//--- design/passthru_top.sv
// bridge top: input synchronizers, esp32 boot control, flash spi bridge,
// apb registers and led mux; pads are built by the board wrapper
`timescale 1ns/1ps

module passthru_top (
  input  logic                      clk_25mhz,
  input  logic                      rst,
  input  passthru_pkg::apb_req_t    apb_req,
  output passthru_pkg::apb_rsp_t    apb_rsp,
  input  passthru_pkg::modem_t      modem_raw,
  input  passthru_pkg::btn_t        btn_raw,
  input  logic                      ftdi_txd,
  output logic                      ftdi_rxd,
  input  logic                      wifi_txd,
  output logic                      wifi_rxd,
  input  passthru_pkg::spi_bus_t    spi_host,
  output logic                      spi_miso,
  output passthru_pkg::spi_bus_t    flash_bus,
  input  logic                      flash_miso,
  output logic                      flash_wpn,
  output logic                      flash_holdn,
  output passthru_pkg::boot_drive_t boot_drive,
  output logic [7:0]                led
);
  import passthru_pkg::*;

  modem_t      modem_sync;
  btn_t        btn_sync;
  ctrl_t       ctrl;
  status_t     status;
  logic [15:0] frame_count;
  logic        frames_clear;

  // serial lines straight through
  assign ftdi_rxd = wifi_txd;
  assign wifi_rxd = ftdi_txd;

  sync_stage #(.T(modem_t)) u_modem_sync (
    .clk_25mhz (clk_25mhz),
    .rst       (rst),
    .d         (modem_raw),
    .q         (modem_sync)
  );

  sync_stage #(.T(btn_t)) u_btn_sync (
    .clk_25mhz (clk_25mhz),
    .rst       (rst),
    .d         (btn_raw),
    .q         (btn_sync)
  );

  esp32_boot_ctrl u_esp32_boot_ctrl (
    .clk_25mhz    (clk_25mhz),
    .rst          (rst),
    .modem        (modem_sync),
    .esp_hold_btn (btn_sync.esp_hold),
    .ctrl         (ctrl),
    .drive        (boot_drive),
    .status       (status)
  );

  flash_spi_bridge u_flash_spi_bridge (
    .clk_25mhz    (clk_25mhz),
    .rst          (rst),
    .flash_reset  (btn_sync.flash_reset),
    .host         (spi_host),
    .host_miso    (spi_miso),
    .flash        (flash_bus),
    .flash_miso   (flash_miso),
    .flash_wpn    (flash_wpn),
    .flash_holdn  (flash_holdn),
    .frames_clear (frames_clear),
    .frame_count  (frame_count)
  );

  apb_ctrl_regs u_apb_ctrl_regs (
    .clk_25mhz    (clk_25mhz),
    .rst          (rst),
    .req          (apb_req),
    .rsp          (apb_rsp),
    .ctrl         (ctrl),
    .status       (status),
    .frame_count  (frame_count),
    .frames_clear (frames_clear)
  );

  // rx is esp32 to host, tx is host to esp32
  led_status_mux u_led_status_mux (
    .clk_25mhz (clk_25mhz),
    .rst       (rst),
    .mode      (ctrl.led_mode),
    .host      (spi_host),
    .host_miso (spi_miso),
    .status    (status),
    .serial_rx (wifi_txd),
    .serial_tx (ftdi_txd),
    .led       (led)
  );

endmodule

//--- tb/passthru_properties.sv
// concurrent assertions on apb response rules and esp32 boot pin drive
`timescale 1ns/1ps

module passthru_properties (
  input logic                      clk_25mhz,
  input logic                      rst,
  input logic                      apb_en,  // apb rules armed
  input logic                      boot_en, // boot pin rules armed
  input passthru_pkg::apb_req_t    req,
  input passthru_pkg::apb_rsp_t    rsp,
  input passthru_pkg::boot_drive_t drive
);

  // zero wait states, always ready
  a_pready_high : assert property (@(posedge clk_25mhz) disable iff (rst || !apb_en)
    rsp.pready)
    else $error("pready dropped low");

  a_slverr_access : assert property (@(posedge clk_25mhz) disable iff (rst || !apb_en)
    rsp.pslverr |-> (req.psel && req.penable)) // error only in access phase
    else $error("pslverr raised outside the access phase");

  // flash voltage strap must never see a driven 1
  a_gpio12_low : assert property (@(posedge clk_25mhz) disable iff (rst || !boot_en)
    drive.gpio12_oe |-> !drive.gpio12)
    else $error("gpio12 driven high");

endmodule

//--- tb/tb_passthru.sv
// testbench for the bridge top: apb tasks, directed and random stimulus,
// boot drive reference model with a per-cycle comparison
`timescale 1ns/1ps

module tb_passthru;
  import passthru_pkg::*;

  localparam int TIMEOUT_CYCLES = 6000; // random walk < 700 cycles, directed < 1500

  logic        clk_25mhz;
  logic        rst;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  modem_t      modem_raw;
  btn_t        btn_raw;
  logic        ftdi_txd;
  logic        ftdi_rxd;
  logic        wifi_txd;
  logic        wifi_rxd;
  spi_bus_t    spi_host;
  spi_bus_t    flash_bus;
  logic        spi_miso;
  logic        flash_miso;
  logic        flash_wpn;
  logic        flash_holdn;
  boot_drive_t boot_drive;
  logic [7:0]  led;

  int          errors = 0;
  int          cycle_cnt = 0;
  logic        checking = 1'b0;
  // reference model state
  logic [1:0]  sa;   // modem sync copy
  logic [1:0]  sb;
  logic [1:0]  lq;   // previous lines
  btn_t        ba;
  btn_t        bb;
  int          rel;
  int          pu;
  int          m_log2;
  logic        prog;
  logic        progn;
  logic        entry;
  logic        m_hold;
  boot_drive_t exp_drive;

  passthru_top u_passthru_top (
    .clk_25mhz (clk_25mhz), .rst (rst),
    .apb_req (apb_req), .apb_rsp (apb_rsp),
    .modem_raw (modem_raw), .btn_raw (btn_raw),
    .ftdi_txd (ftdi_txd), .ftdi_rxd (ftdi_rxd),
    .wifi_txd (wifi_txd), .wifi_rxd (wifi_rxd),
    .spi_host (spi_host), .spi_miso (spi_miso),
    .flash_bus (flash_bus), .flash_miso (flash_miso),
    .flash_wpn (flash_wpn), .flash_holdn (flash_holdn),
    .boot_drive (boot_drive), .led (led)
  );

  bind apb_ctrl_regs passthru_properties u_apb_props (
    .clk_25mhz (clk_25mhz), .rst (rst), .apb_en (1'b1), .boot_en (1'b0),
    .req (req), .rsp (rsp), .drive ('0)
  );

  bind esp32_boot_ctrl passthru_properties u_boot_props (
    .clk_25mhz (clk_25mhz), .rst (rst), .apb_en (1'b0), .boot_en (1'b1),
    .req ('0), .rsp ('0), .drive (drive)
  );

  initial
  begin
    clk_25mhz = 1'b0;
    forever #20 clk_25mhz = ~clk_25mhz; // 40 ns
  end

  // expected pin drive from decoded lines, hold, power-up state and strap flag
  function automatic boot_drive_t boot_ref(logic [1:0] lines, logic hold, logic pu_done,
                                           logic straps);
    boot_drive_t r;
    logic        io0;
    io0 = (lines == 2'b01) ? 1'b0 : 1'b1; // dtr=0 rts=1 pulls io0 low
    r = '0;
    r.en_oe = !pu_done || hold || (lines == 2'b10);
    r.gpio0 = io0;
    r.gpio2 = io0;
    r.gpio4 = 1'b1;
    r.gpio13 = 1'b1;
    {r.gpio0_oe, r.gpio2_oe, r.gpio4_oe, r.gpio12_oe, r.gpio13_oe} = {5{straps}};
    return r;
  endfunction

  // model steps on the edge, inputs here are stable since driven 2 ns later
  always @(posedge clk_25mhz)
  begin
    if (rst)
    begin
      sa = 2'b11;
      sb = 2'b11;
      lq = 2'b11;
      ba = '1;
      bb = '1;
      rel = 0;
      pu = 0;
      prog = 1'b0;
      m_hold = 1'b0;
      m_log2 = 26;
      exp_drive = '0;
      exp_drive.en_oe = 1'b1;
    end
    else
    begin
      entry = (sb == 2'b10) && (lq != 2'b10);
      progn = prog;
      if (entry)
      begin
        rel = 0;
        progn = 1'b1;
      end
      else if (prog)
      begin
        rel++;
        progn = rel < (1 << m_log2);
      end
      exp_drive = boot_ref(sb, m_hold || bb.esp_hold, pu >= 16, progn);
      lq = sb;
      prog = progn;
      if (pu < 16)
        pu++;
      sb = sa; // two sync flops
      sa = modem_raw;
      bb = ba;
      ba = btn_raw;
      if (apb_req.psel && apb_req.penable && apb_req.pwrite && apb_req.paddr == ADDR_CTRL)
      begin
        m_hold = apb_req.pwdata[0];
        m_log2 = (apb_req.pwdata[12:8] > 26) ? 26 : int'(apb_req.pwdata[12:8]);
      end
    end
  end

  // comparison on the falling edge, away from all updates
  always @(negedge clk_25mhz)
  begin
    if (checking)
      check_eq("boot_drive", 32'(boot_drive), 32'(exp_drive));
  end

  always @(posedge clk_25mhz)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic check_eq(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic cycles(int n); // ends 2 ns past an edge
    repeat (n) @(posedge clk_25mhz);
    #2;
  endtask

  task automatic apb_write(logic [3:0] addr, logic [31:0] data);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    cycles(1);
    apb_req.penable = 1'b1;
    cycles(1);
    apb_req = '0;
  endtask

  task automatic apb_read(logic [3:0] addr, output logic [31:0] data, output logic err);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    cycles(1);
    apb_req.penable = 1'b1;
    @(negedge clk_25mhz);
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    cycles(1);
    apb_req = '0;
  endtask

  task automatic wait_led(int idx, logic val, int limit, string what);
    int n;
    n = 0;
    while (led[idx] !== val && n < limit)
    begin
      @(negedge clk_25mhz);
      n++;
    end
    check_eq(what, 32'(led[idx]), 32'(val));
    cycles(1);
  endtask

  task automatic count_strap_cycles(output int n);
    n = 0;
    while (!boot_drive.gpio0_oe && n < 10)
    begin
      @(negedge clk_25mhz);
      n++;
    end
    n = 0;
    while (boot_drive.gpio0_oe && n < 100)
    begin
      @(negedge clk_25mhz);
      n++;
    end
    cycles(1);
  endtask

  initial
  begin
    logic [31:0] rd;
    logic        err;
    int          n;
    void'($urandom(32'hedaa));
    apb_req = '0;
    modem_raw = 2'b11;
    btn_raw = '0;
    ftdi_txd = 1'b1;
    wifi_txd = 1'b1;
    spi_host = '{sck: 1'b0, mosi: 1'b0, csn: 1'b1};
    flash_miso = 1'b0;
    rst = 1'b1;
    repeat (8) @(posedge clk_25mhz);
    #2 rst = 1'b0;
    checking = 1'b1;

    // power-up hold, then status
    cycles(20);
    check_eq("strap oe after reset", 32'(boot_drive.gpio0_oe), 0);
    apb_read(ADDR_STATUS, rd, err);
    check_eq("status after power-up", rd, 32'h3);

    // random modem walk, model checks every cycle
    apb_write(ADDR_CTRL, 32'(5) << 8);
    for (int i = 0; i < 40; i++)
    begin
      modem_raw = 2'($urandom_range(0, 3));
      cycles($urandom_range(1, 12));
    end
    modem_raw = 2'b11;
    cycles(40);

    // exact release timeout, then a re-entry
    modem_raw = 2'b10;
    cycles(1);
    modem_raw = 2'b11;
    count_strap_cycles(n);
    check_eq("strap cycles", 32'(n), 32);
    modem_raw = 2'b10;
    cycles(20);
    modem_raw = 2'b11;
    cycles(3);
    modem_raw = 2'b10; // restarts count
    cycles(50);
    modem_raw = 2'b11;
    cycles(5);

    // registers
    apb_write(ADDR_CTRL, 32'h1 | (32'd31 << 8) | (32'd2 << 16));
    apb_read(ADDR_CTRL, rd, err);
    check_eq("ctrl readback clipped", rd, 32'h1 | (32'd26 << 8) | (32'd2 << 16));
    cycles(2);
    check_eq("en held by esp_hold", 32'(boot_drive.en_oe), 1);
    apb_write(ADDR_STATUS, 32'hffff_ffff); // ignored
    apb_write(ADDR_CTRL, 32'(5) << 8);
    apb_read(4'hc, rd, err);
    check_eq("pslverr unmapped", 32'(err), 1);
    apb_read(ADDR_STATUS, rd, err);
    check_eq("pslverr mapped", 32'(err), 0);
    check_eq("status after write", rd, 32'h3);
    btn_raw.esp_hold = 1'b1;
    cycles(4);
    check_eq("en held by button", 32'(boot_drive.en_oe), 1);
    btn_raw.esp_hold = 1'b0;
    cycles(4);
    check_eq("en released", 32'(boot_drive.en_oe), 0);

    // flash and serial passthrough
    check_eq("flash wpn", 32'(flash_wpn), 1);
    check_eq("flash holdn", 32'(flash_holdn), 1);
    spi_host.mosi = 1'b1;
    #1 check_eq("flash mosi", 32'(flash_bus.mosi), 1);
    spi_host.csn = 1'b0;
    #1 check_eq("flash csn", 32'(flash_bus.csn), 0);
    flash_miso = 1'b1;
    #1 check_eq("host miso", 32'(spi_miso), 1);
    wifi_txd = 1'b0;
    ftdi_txd = 1'b0;
    #1 check_eq("ftdi_rxd", 32'(ftdi_rxd), 0);
    check_eq("wifi_rxd", 32'(wifi_rxd), 0);
    spi_host = '{sck: 1'b0, mosi: 1'b0, csn: 1'b1};
    flash_miso = 1'b0;
    wifi_txd = 1'b1;
    ftdi_txd = 1'b1;
    cycles(1);
    btn_raw.flash_reset = 1'b1;
    cycles(3);
    spi_host.sck = 1'b1;
    #1 check_eq("sck gated", 32'(flash_bus.sck), 0);
    btn_raw.flash_reset = 1'b0;
    spi_host.sck = 1'b0;
    cycles(3);
    spi_host.sck = 1'b1;
    #1 check_eq("sck passed", 32'(flash_bus.sck), 1);
    spi_host.sck = 1'b0;
    cycles(5);
    apb_write(ADDR_FRAMES, 32'h0);
    for (int i = 0; i < 5; i++)
    begin
      spi_host.csn = 1'b0;
      cycles(3);
      spi_host.csn = 1'b1;
      cycles(3);
    end
    cycles(4);
    apb_read(ADDR_FRAMES, rd, err);
    check_eq("frame count", rd, 5);
    apb_write(ADDR_FRAMES, 32'h1234);
    apb_read(ADDR_FRAMES, rd, err);
    check_eq("frame count cleared", rd, 0);

    // led modes
    cycles(12);
    spi_host.sck = 1'b1;
    wait_led(0, 1'b1, 4, "spi led on");
    check_eq("spi led upper", 32'(led[7:4]), 0);
    wait_led(0, 1'b0, STRETCH_CYCLES + 3, "spi led off");
    apb_write(ADDR_CTRL, (32'd2 << 16) | (32'd5 << 8));
    wifi_txd = 1'b0;
    wait_led(0, 1'b1, 4, "rx led on");
    check_eq("tx led idle", 32'(led[1]), 0);
    wait_led(0, 1'b0, STRETCH_CYCLES + 3, "rx led off");
    ftdi_txd = 1'b0;
    wait_led(1, 1'b1, 4, "tx led on");
    wait_led(1, 1'b0, STRETCH_CYCLES + 3, "tx led off");
    apb_write(ADDR_CTRL, (32'd1 << 16) | (32'd5 << 8));
    @(negedge clk_25mhz);
    check_eq("boot leds", 32'(led), 32'({prog, !exp_drive.en_oe, pu >= 16}));
    cycles(1);
    apb_write(ADDR_CTRL, (32'd3 << 16) | (32'd5 << 8));
    spi_host.sck = 1'b0;
    wifi_txd = 1'b1;
    cycles(3);
    check_eq("leds off", 32'(led), 0);
    cycles(2);

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- vlog.f
design/passthru_pkg.sv
design/sync_stage.sv
design/esp32_boot_ctrl.sv
design/flash_spi_bridge.sv
design/apb_ctrl_regs.sv
design/led_status_mux.sv
design/passthru_top.sv
tb/passthru_properties.sv
tb/tb_passthru.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, result decided from the log
verilator --binary --assert --timing -f vlog.f --top-module tb_passthru -o tb_passthru \
  || { echo "build failed"; exit 1; }
./obj_dir/tb_passthru > sim.log 2>&1 \
  || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "test failed"; exit 1; } \
  || echo "test passed"
